/* include/noc_defines.svh */
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// flit and packet field widths.
`define NOC_FLIT_DATA_WIDTH    40
`define NOC_ID_WIDTH           4
`define NOC_TAG_WIDTH          4
`define NOC_BURST_LENGTH_WIDTH 8
`define NOC_ADDRESS_WIDTH      32
`define NOC_DATA_WIDTH         32
`define NOC_BYTE_ENABLE_WIDTH  4

// a header always spans this many flits.
`define NOC_HEADER_FLITS       2

// link buffer entries.
`define NOC_FIFO_DEPTH         4

`endif

/* verilog/noc_pkg.sv */
`default_nettype none

`include "noc_defines.svh"

package noc_pkg;

  typedef enum logic [1:0] {
    read_request,
    write_request,
    read_response,
    write_response
  } packet_type_e;

  typedef enum logic {
    header_flit,
    payload_flit
  } flit_kind_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // header image, lsb first.
  localparam int status_width       = 2;
  localparam int packet_type_lsb    = 0;
  localparam int destination_id_lsb = packet_type_lsb + $bits(packet_type_e);
  localparam int source_id_lsb      = destination_id_lsb + `NOC_ID_WIDTH;
  localparam int tag_lsb            = source_id_lsb + `NOC_ID_WIDTH;
  localparam int burst_length_lsb   = tag_lsb + `NOC_TAG_WIDTH;
  localparam int status_lsb         = burst_length_lsb + `NOC_BURST_LENGTH_WIDTH;
  localparam int address_lsb        = status_lsb + status_width;
  localparam int header_data_width  = `NOC_HEADER_FLITS * `NOC_FLIT_DATA_WIDTH;
  localparam int header_count_width = $clog2(`NOC_HEADER_FLITS);

  typedef logic [header_count_width-1:0] header_count_t;

  localparam header_count_t last_header_count = header_count_t'(`NOC_HEADER_FLITS - 1);

  // payload image, byte enables sit above the data.
  localparam int byte_enable_lsb = `NOC_DATA_WIDTH;

  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic has_payload(packet_type_e packet_type);
    return (packet_type == write_request) || (packet_type == read_response);
  endfunction

endpackage

`default_nettype wire

/* verilog/noc_packet_packer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_defines.svh"

module noc_packet_packer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               tx_header_valid,
  output logic                               tx_header_ready,
  input  noc_pkg::packet_type_e              packet_type,
  input  logic [`NOC_ID_WIDTH-1:0]           destination_id,
  input  logic [`NOC_ID_WIDTH-1:0]           source_id,
  input  logic [`NOC_TAG_WIDTH-1:0]          tag,
  input  logic [`NOC_BURST_LENGTH_WIDTH-1:0] burst_length,
  input  logic [`NOC_ADDRESS_WIDTH-1:0]      address,
  input  logic [noc_pkg::status_width-1:0]   status,
  input  logic                               tx_payload_valid,
  output logic                               tx_payload_ready,
  input  logic                               payload_last,
  input  logic [`NOC_DATA_WIDTH-1:0]         data,
  input  logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  byte_enable,
  output logic                               flit_valid,
  input  logic                               flit_ready,
  output noc_pkg::flit_kind_e                flit_kind,
  output logic                               flit_tail,
  output logic [`NOC_FLIT_DATA_WIDTH-1:0]    flit_data
);

  typedef enum logic {
    header_mode,
    payload_mode
  } mode_e;

  mode_e                                 mode;
  noc_pkg::header_count_t                flit_count;
  logic                                  header_flit_last;
  logic [noc_pkg::header_data_width-1:0] header_data;
  logic [`NOC_FLIT_DATA_WIDTH-1:0]       payload_data;

  // ~~~~~~~~~~~~~~~~~~~~
  // flit images.
  always_comb begin
    header_data = '0;
    header_data[noc_pkg::packet_type_lsb +: $bits(noc_pkg::packet_type_e)] = packet_type;
    header_data[noc_pkg::destination_id_lsb +: `NOC_ID_WIDTH] = destination_id;
    header_data[noc_pkg::source_id_lsb +: `NOC_ID_WIDTH] = source_id;
    header_data[noc_pkg::tag_lsb +: `NOC_TAG_WIDTH] = tag;
    header_data[noc_pkg::burst_length_lsb +: `NOC_BURST_LENGTH_WIDTH] = burst_length;
    header_data[noc_pkg::status_lsb +: noc_pkg::status_width] = status;
    header_data[noc_pkg::address_lsb +: `NOC_ADDRESS_WIDTH] = address;
  end

  always_comb begin
    payload_data = '0;
    payload_data[0 +: `NOC_DATA_WIDTH] = data;
    payload_data[noc_pkg::byte_enable_lsb +: `NOC_BYTE_ENABLE_WIDTH] = byte_enable;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // flit channel.
  assign header_flit_last = flit_count == noc_pkg::last_header_count;

  always_comb begin
    if (mode == header_mode) begin
      flit_valid = tx_header_valid;
      flit_kind  = noc_pkg::header_flit;
      // header-only packets end on their last header flit.
      flit_tail  = header_flit_last && !noc_pkg::has_payload(packet_type);
      flit_data  = header_data[flit_count * `NOC_FLIT_DATA_WIDTH +: `NOC_FLIT_DATA_WIDTH];
    end else begin
      flit_valid = tx_payload_valid;
      flit_kind  = noc_pkg::payload_flit;
      flit_tail  = payload_last;
      flit_data  = payload_data;
    end
  end

  // the header is released only with its last flit.
  assign tx_header_ready  = (mode == header_mode) && header_flit_last &&
                            tx_header_valid && flit_ready;
  assign tx_payload_ready = (mode == payload_mode) && flit_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode       <= header_mode;
      flit_count <= '0;
    end else if (flit_valid && flit_ready) begin
      if (mode == payload_mode) begin
        if (flit_tail) begin
          mode <= header_mode;
        end
      end else if (header_flit_last) begin
        flit_count <= '0;
        if (noc_pkg::has_payload(packet_type)) begin
          mode <= payload_mode;
        end
      end else begin
        flit_count <= flit_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/noc_flit_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_defines.svh"

module noc_flit_fifo (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  noc_pkg::flit_kind_e             in_kind,
  input  logic                            in_tail,
  input  logic [`NOC_FLIT_DATA_WIDTH-1:0] in_data,
  output logic                            out_valid,
  input  logic                            out_ready,
  output noc_pkg::flit_kind_e             out_kind,
  output logic                            out_tail,
  output logic [`NOC_FLIT_DATA_WIDTH-1:0] out_data
);

  localparam int entry_width = `NOC_FLIT_DATA_WIDTH + 2;
  localparam int ptr_width   = $clog2(`NOC_FIFO_DEPTH);

  typedef logic [ptr_width-1:0] ptr_t;

  localparam logic [ptr_width:0] full_count = `NOC_FIFO_DEPTH;

  logic [entry_width-1:0] storage [`NOC_FIFO_DEPTH];
  ptr_t                   wr_ptr;
  ptr_t                   rd_ptr;
  logic [ptr_width:0]     count;
  logic                   push;
  logic                   pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(`NOC_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // a full buffer still takes a flit when one leaves in the same cycle.
  assign in_ready  = (count != full_count) || out_ready;
  assign out_valid = count != '0;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      storage[wr_ptr] <= {in_kind, in_tail, in_data};
    end
  end

  assign out_kind = noc_pkg::flit_kind_e'(storage[rd_ptr][entry_width-1]);
  assign out_tail = storage[rd_ptr][entry_width-2];
  assign out_data = storage[rd_ptr][`NOC_FLIT_DATA_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/noc_packet_unpacker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_defines.svh"

module noc_packet_unpacker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flit_valid,
  output logic                               flit_ready,
  input  noc_pkg::flit_kind_e                flit_kind,
  input  logic                               flit_tail,
  input  logic [`NOC_FLIT_DATA_WIDTH-1:0]    flit_data,
  output logic                               rx_header_valid,
  input  logic                               rx_header_ready,
  output noc_pkg::packet_type_e              packet_type,
  output logic [`NOC_ID_WIDTH-1:0]           destination_id,
  output logic [`NOC_ID_WIDTH-1:0]           source_id,
  output logic [`NOC_TAG_WIDTH-1:0]          tag,
  output logic [`NOC_BURST_LENGTH_WIDTH-1:0] burst_length,
  output logic [`NOC_ADDRESS_WIDTH-1:0]      address,
  output logic [noc_pkg::status_width-1:0]   status,
  output logic                               rx_payload_valid,
  input  logic                               rx_payload_ready,
  output logic                               payload_last,
  output logic [`NOC_DATA_WIDTH-1:0]         data,
  output logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  byte_enable
);

  logic                                  header_flit_valid;
  logic                                  header_flit_ready;
  logic                                  header_flit_last;
  noc_pkg::header_count_t                flit_count;
  logic [`NOC_FLIT_DATA_WIDTH-1:0]       flit_buffer [`NOC_HEADER_FLITS-1];
  logic [noc_pkg::header_data_width-1:0] header_data;

  // steer by flit kind.
  assign header_flit_valid = flit_valid && (flit_kind == noc_pkg::header_flit);
  assign rx_payload_valid  = flit_valid && (flit_kind == noc_pkg::payload_flit);
  assign flit_ready        = (flit_kind == noc_pkg::header_flit) ? header_flit_ready :
                                                                   rx_payload_ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // header collection.
  assign header_flit_last  = flit_count == noc_pkg::last_header_count;
  assign rx_header_valid   = header_flit_valid && header_flit_last;
  assign header_flit_ready = header_flit_last ? rx_header_ready : 1'b1;

  for (genvar i = 0; i < `NOC_HEADER_FLITS; i++) begin : g_header_slice
    if (i < `NOC_HEADER_FLITS - 1) begin : g_buffered
      assign header_data[i*`NOC_FLIT_DATA_WIDTH +: `NOC_FLIT_DATA_WIDTH] = flit_buffer[i];
    end else begin : g_current
      assign header_data[i*`NOC_FLIT_DATA_WIDTH +: `NOC_FLIT_DATA_WIDTH] = flit_data;
    end
  end

  // earlier header flits are taken at once and held here.
  always_ff @(posedge clk) begin
    if (header_flit_valid && !header_flit_last) begin
      flit_buffer[flit_count] <= flit_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_count <= '0;
    end else if (header_flit_valid && header_flit_ready) begin
      flit_count <= header_flit_last ? '0 : flit_count + 1'b1;
    end
  end

  assign packet_type    = noc_pkg::packet_type_e'(
    header_data[noc_pkg::packet_type_lsb +: $bits(noc_pkg::packet_type_e)]);
  assign destination_id = header_data[noc_pkg::destination_id_lsb +: `NOC_ID_WIDTH];
  assign source_id      = header_data[noc_pkg::source_id_lsb +: `NOC_ID_WIDTH];
  assign tag            = header_data[noc_pkg::tag_lsb +: `NOC_TAG_WIDTH];
  assign burst_length   = header_data[noc_pkg::burst_length_lsb +: `NOC_BURST_LENGTH_WIDTH];
  assign status         = header_data[noc_pkg::status_lsb +: noc_pkg::status_width];
  assign address        = header_data[noc_pkg::address_lsb +: `NOC_ADDRESS_WIDTH];

  // ~~~~~~~~~~~~~~~~~~~~
  // payload beats, one per flit.
  assign payload_last = flit_tail;
  assign data         = flit_data[0 +: `NOC_DATA_WIDTH];
  assign byte_enable  = flit_data[noc_pkg::byte_enable_lsb +: `NOC_BYTE_ENABLE_WIDTH];

endmodule

`default_nettype wire

/* verilog/noc_packet_link.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_defines.svh"

module noc_packet_link (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               tx_header_valid,
  output logic                               tx_header_ready,
  input  noc_pkg::packet_type_e              tx_packet_type,
  input  logic [`NOC_ID_WIDTH-1:0]           tx_destination_id,
  input  logic [`NOC_ID_WIDTH-1:0]           tx_source_id,
  input  logic [`NOC_TAG_WIDTH-1:0]          tx_tag,
  input  logic [`NOC_BURST_LENGTH_WIDTH-1:0] tx_burst_length,
  input  logic [`NOC_ADDRESS_WIDTH-1:0]      tx_address,
  input  logic [noc_pkg::status_width-1:0]   tx_status,
  input  logic                               tx_payload_valid,
  output logic                               tx_payload_ready,
  input  logic                               tx_payload_last,
  input  logic [`NOC_DATA_WIDTH-1:0]         tx_data,
  input  logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  tx_byte_enable,
  output logic                               rx_header_valid,
  input  logic                               rx_header_ready,
  output noc_pkg::packet_type_e              rx_packet_type,
  output logic [`NOC_ID_WIDTH-1:0]           rx_destination_id,
  output logic [`NOC_ID_WIDTH-1:0]           rx_source_id,
  output logic [`NOC_TAG_WIDTH-1:0]          rx_tag,
  output logic [`NOC_BURST_LENGTH_WIDTH-1:0] rx_burst_length,
  output logic [`NOC_ADDRESS_WIDTH-1:0]      rx_address,
  output logic [noc_pkg::status_width-1:0]   rx_status,
  output logic                               rx_payload_valid,
  input  logic                               rx_payload_ready,
  output logic                               rx_payload_last,
  output logic [`NOC_DATA_WIDTH-1:0]         rx_data,
  output logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  rx_byte_enable
);

  // flits from the packer into the link buffer.
  logic                            in_flit_valid;
  logic                            in_flit_ready;
  noc_pkg::flit_kind_e             in_flit_kind;
  logic                            in_flit_tail;
  logic [`NOC_FLIT_DATA_WIDTH-1:0] in_flit_data;

  // flits from the link buffer into the unpacker.
  logic                            out_flit_valid;
  logic                            out_flit_ready;
  noc_pkg::flit_kind_e             out_flit_kind;
  logic                            out_flit_tail;
  logic [`NOC_FLIT_DATA_WIDTH-1:0] out_flit_data;

  noc_packet_packer u_packer (
    .clk              (clk),
    .rst_n            (rst_n),
    .tx_header_valid  (tx_header_valid),
    .tx_header_ready  (tx_header_ready),
    .packet_type      (tx_packet_type),
    .destination_id   (tx_destination_id),
    .source_id        (tx_source_id),
    .tag              (tx_tag),
    .burst_length     (tx_burst_length),
    .address          (tx_address),
    .status           (tx_status),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready),
    .payload_last     (tx_payload_last),
    .data             (tx_data),
    .byte_enable      (tx_byte_enable),
    .flit_valid       (in_flit_valid),
    .flit_ready       (in_flit_ready),
    .flit_kind        (in_flit_kind),
    .flit_tail        (in_flit_tail),
    .flit_data        (in_flit_data)
  );

  noc_flit_fifo u_flit_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_flit_valid),
    .in_ready  (in_flit_ready),
    .in_kind   (in_flit_kind),
    .in_tail   (in_flit_tail),
    .in_data   (in_flit_data),
    .out_valid (out_flit_valid),
    .out_ready (out_flit_ready),
    .out_kind  (out_flit_kind),
    .out_tail  (out_flit_tail),
    .out_data  (out_flit_data)
  );

  noc_packet_unpacker u_unpacker (
    .clk              (clk),
    .rst_n            (rst_n),
    .flit_valid       (out_flit_valid),
    .flit_ready       (out_flit_ready),
    .flit_kind        (out_flit_kind),
    .flit_tail        (out_flit_tail),
    .flit_data        (out_flit_data),
    .rx_header_valid  (rx_header_valid),
    .rx_header_ready  (rx_header_ready),
    .packet_type      (rx_packet_type),
    .destination_id   (rx_destination_id),
    .source_id        (rx_source_id),
    .tag              (rx_tag),
    .burst_length     (rx_burst_length),
    .address          (rx_address),
    .status           (rx_status),
    .rx_payload_valid (rx_payload_valid),
    .rx_payload_ready (rx_payload_ready),
    .payload_last     (rx_payload_last),
    .data             (rx_data),
    .byte_enable      (rx_byte_enable)
  );

endmodule

`default_nettype wire

/* tests/tb_noc_packet_link.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_defines.svh"

module tb_noc_packet_link;

  localparam int timeout_cycles = 1000;

  typedef struct packed {
    noc_pkg::packet_type_e              packet_type;
    logic [`NOC_ID_WIDTH-1:0]           destination_id;
    logic [`NOC_ID_WIDTH-1:0]           source_id;
    logic [`NOC_TAG_WIDTH-1:0]          tag;
    logic [`NOC_BURST_LENGTH_WIDTH-1:0] burst_length;
    logic [noc_pkg::status_width-1:0]   status;
    logic [`NOC_ADDRESS_WIDTH-1:0]      address;
  } header_t;

  typedef struct packed {
    logic [`NOC_DATA_WIDTH-1:0]        data;
    logic [`NOC_BYTE_ENABLE_WIDTH-1:0] byte_enable;
    logic                              last;
  } beat_t;

  logic                               clk;
  logic                               rst_n;
  logic                               tx_header_valid;
  logic                               tx_header_ready;
  noc_pkg::packet_type_e              tx_packet_type;
  logic [`NOC_ID_WIDTH-1:0]           tx_destination_id;
  logic [`NOC_ID_WIDTH-1:0]           tx_source_id;
  logic [`NOC_TAG_WIDTH-1:0]          tx_tag;
  logic [`NOC_BURST_LENGTH_WIDTH-1:0] tx_burst_length;
  logic [`NOC_ADDRESS_WIDTH-1:0]      tx_address;
  logic [noc_pkg::status_width-1:0]   tx_status;
  logic                               tx_payload_valid;
  logic                               tx_payload_ready;
  logic                               tx_payload_last;
  logic [`NOC_DATA_WIDTH-1:0]         tx_data;
  logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  tx_byte_enable;
  logic                               rx_header_valid;
  logic                               rx_header_ready;
  noc_pkg::packet_type_e              rx_packet_type;
  logic [`NOC_ID_WIDTH-1:0]           rx_destination_id;
  logic [`NOC_ID_WIDTH-1:0]           rx_source_id;
  logic [`NOC_TAG_WIDTH-1:0]          rx_tag;
  logic [`NOC_BURST_LENGTH_WIDTH-1:0] rx_burst_length;
  logic [`NOC_ADDRESS_WIDTH-1:0]      rx_address;
  logic [noc_pkg::status_width-1:0]   rx_status;
  logic                               rx_payload_valid;
  logic                               rx_payload_ready;
  logic                               rx_payload_last;
  logic [`NOC_DATA_WIDTH-1:0]         rx_data;
  logic [`NOC_BYTE_ENABLE_WIDTH-1:0]  rx_byte_enable;

  header_t expected_headers[$];
  beat_t   expected_beats[$];
  int      error_count;

  noc_packet_link u_noc_packet_link (.*);

  always #50 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  task automatic compare_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("timed out after %0d cycles waiting for %s", timeout_cycles, what);
  endtask

  task automatic wait_tx_transfer(input bit payload);
    int   waited;
    logic ready;
    waited = 0;
    do begin
      @(posedge clk);
      ready = payload ? tx_payload_ready : tx_header_ready;
      waited++;
    end while (!ready && waited < timeout_cycles);
    if (!ready) begin
      report_timeout(payload ? "tx_payload_ready" : "tx_header_ready");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tx side, header first and then burst_length beats.
  task automatic send_packet(input header_t header);
    beat_t beat;
    expected_headers.push_back(header);
    @(negedge clk);
    tx_header_valid   = 1'b1;
    tx_packet_type    = header.packet_type;
    tx_destination_id = header.destination_id;
    tx_source_id      = header.source_id;
    tx_tag            = header.tag;
    tx_burst_length   = header.burst_length;
    tx_status         = header.status;
    tx_address        = header.address;
    wait_tx_transfer(1'b0);
    @(negedge clk);
    tx_header_valid = 1'b0;
    if (noc_pkg::has_payload(header.packet_type)) begin
      for (int i = 0; i < int'(header.burst_length); i++) begin
        beat.data        = $urandom;
        beat.byte_enable = 4'($urandom_range(0, 15));
        beat.last        = (i == int'(header.burst_length) - 1);
        expected_beats.push_back(beat);
        tx_payload_valid = 1'b1;
        tx_data          = beat.data;
        tx_byte_enable   = beat.byte_enable;
        tx_payload_last  = beat.last;
        wait_tx_transfer(1'b1);
        @(negedge clk);
      end
    end
    tx_payload_valid = 1'b0;
  endtask

  // rx side, optionally with random ready stretches.
  task automatic receive_packets(input int count, input bit stall);
    header_t header;
    beat_t   beat;
    int      received;
    int      beats_left;
    int      waited;
    int      hold;
    received   = 0;
    beats_left = 0;
    waited     = 0;
    hold       = 0;
    while (received < count && waited < timeout_cycles) begin
      @(negedge clk);
      if (hold > 0) begin
        hold--;
      end else begin
        hold             = stall ? $urandom_range(0, 7) : 0;
        rx_header_ready  = !stall || ($urandom_range(0, 2) != 0);
        rx_payload_ready = !stall || ($urandom_range(0, 2) != 0);
      end
      @(posedge clk);
      waited++;
      if (rx_header_valid && rx_header_ready) begin
        waited = 0;
        if (beats_left != 0 || expected_headers.size() == 0) begin
          error_count++;
          $display("a header arrived while payload beats or nothing were expected");
        end else begin
          header = expected_headers.pop_front();
          compare_field("rx_packet_type", 64'(header.packet_type), 64'(rx_packet_type));
          compare_field("rx_destination_id", 64'(header.destination_id),
                        64'(rx_destination_id));
          compare_field("rx_source_id", 64'(header.source_id), 64'(rx_source_id));
          compare_field("rx_tag", 64'(header.tag), 64'(rx_tag));
          compare_field("rx_burst_length", 64'(header.burst_length), 64'(rx_burst_length));
          compare_field("rx_status", 64'(header.status), 64'(rx_status));
          compare_field("rx_address", 64'(header.address), 64'(rx_address));
          beats_left = noc_pkg::has_payload(header.packet_type) ?
                       int'(header.burst_length) : 0;
          if (beats_left == 0) begin
            received++;
          end
        end
      end
      if (rx_payload_valid && rx_payload_ready) begin
        waited = 0;
        if (beats_left == 0 || expected_beats.size() == 0) begin
          error_count++;
          $display("a payload beat arrived while a header was expected");
        end else begin
          beat = expected_beats.pop_front();
          compare_field("rx_data", 64'(beat.data), 64'(rx_data));
          compare_field("rx_byte_enable", 64'(beat.byte_enable), 64'(rx_byte_enable));
          compare_field("rx_payload_last", 64'(beat.last), 64'(rx_payload_last));
          beats_left--;
          if (beats_left == 0) begin
            received++;
          end
        end
      end
    end
    if (received < count) begin
      report_timeout("rx packets");
    end
  endtask

  task automatic check_drained();
    if (expected_headers.size() != 0 || expected_beats.size() != 0) begin
      error_count++;
      $display("packets were sent but never delivered");
    end
  endtask

  function automatic header_t random_header();
    header_t header;
    header.packet_type    = noc_pkg::packet_type_e'($urandom_range(0, 3));
    header.destination_id = 4'($urandom);
    header.source_id      = 4'($urandom);
    header.tag            = 4'($urandom);
    header.burst_length   = noc_pkg::has_payload(header.packet_type) ?
                            8'($urandom_range(1, 6)) : 8'($urandom);
    header.status         = 2'($urandom);
    header.address        = $urandom;
    return header;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_state();
    @(posedge clk);
    compare_field("rx_header_valid", 64'(0), 64'(rx_header_valid));
    compare_field("rx_payload_valid", 64'(0), 64'(rx_payload_valid));
    compare_field("tx_header_ready", 64'(0), 64'(tx_header_ready));
    compare_field("tx_payload_ready", 64'(0), 64'(tx_payload_ready));
  endtask

  task automatic test_write_request();
    fork
      send_packet(header_t'{noc_pkg::write_request, 4'h3, 4'h1, 4'ha, 8'd4, 2'b00,
                            32'h8000_1000});
      receive_packets(1, 1'b0);
    join
    check_drained();
  endtask

  task automatic test_header_only();
    fork
      begin
        send_packet(header_t'{noc_pkg::read_request, 4'h5, 4'h2, 4'h7, 8'd8, 2'b00,
                              32'h0000_4040});
        send_packet(header_t'{noc_pkg::write_response, 4'h2, 4'h5, 4'ha, 8'd0, 2'b01,
                              32'h0});
      end
      receive_packets(2, 1'b0);
    join
    check_drained();
  endtask

  task automatic test_read_response();
    fork
      send_packet(header_t'{noc_pkg::read_response, 4'h1, 4'h6, 4'hc, 8'd3, 2'b10,
                            32'hdead_0100});
      receive_packets(1, 1'b0);
    join
    check_drained();
  endtask

  // rx ready is held low long enough for the link buffer to fill.
  task automatic test_back_pressure();
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          send_packet(random_header());
        end
      end
      begin
        @(negedge clk);
        rx_header_ready  = 1'b0;
        rx_payload_ready = 1'b0;
        repeat (30) @(negedge clk);
        @(posedge clk);
        compare_field("tx_header_ready", 64'(0), 64'(tx_header_ready));
        compare_field("tx_payload_ready", 64'(0), 64'(tx_payload_ready));
        if (!tx_header_valid && !tx_payload_valid) begin
          error_count++;
          $display("the sender was idle during the stall window");
        end
        receive_packets(8, 1'b1);
      end
    join
    check_drained();
  endtask

  initial begin
    void'($urandom(32'h3105));
    error_count       = 0;
    clk               = 1'b0;
    rst_n             = 1'b0;
    tx_header_valid   = 1'b0;
    tx_packet_type    = noc_pkg::read_request;
    tx_destination_id = '0;
    tx_source_id      = '0;
    tx_tag            = '0;
    tx_burst_length   = '0;
    tx_address        = '0;
    tx_status         = '0;
    tx_payload_valid  = 1'b0;
    tx_payload_last   = 1'b0;
    tx_data           = '0;
    tx_byte_enable    = '0;
    rx_header_ready   = 1'b0;
    rx_payload_ready  = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_write_request();
    test_header_only();
    test_read_response();
    test_back_pressure();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
verilog/noc_pkg.sv
verilog/noc_packet_packer.sv
verilog/noc_flit_fifo.sv
verilog/noc_packet_unpacker.sv
verilog/noc_packet_link.sv
tests/tb_noc_packet_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module tb_noc_packet_link \
  -o sim_noc_packet_link \
  && ./obj_dir/sim_noc_packet_link > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1
